//--- hdl/icache_cfg_pkg.sv
package icache_cfg_pkg;

    // geometry of the L1 instruction cache tag side.
    // address split is tag | index | offset, offset lives in the data side.

    // tag bits kept per entry.
    localparam int DEF_TAG_W = 52;

    // index bits, 64 entries.
    localparam int DEF_INDEX_W = 6;

endpackage

//--- hdl/icache_state_pkg.sv
package icache_state_pkg;

    // controller states of the miss path
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0, // ready for a request.
        ST_LOOKUP    = 2'd1, // compare latched request.
        ST_MISS_WAIT = 2'd2, // waiting on L2.
        ST_REFILL    = 2'd3  // one-cycle refill report.
    } ctrl_state_t;

endpackage

//--- hdl/icache_tag_store.sv
`timescale 1ns/1ps

module icache_tag_store #(
    parameter int TAG_W   = icache_cfg_pkg::DEF_TAG_W,
    parameter int INDEX_W = icache_cfg_pkg::DEF_INDEX_W
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               flush,
    input  logic               fill,
    input  logic [INDEX_W-1:0] req_index,
    input  logic [TAG_W-1:0]   req_tag,
    output logic               hit
);

    localparam int ENTRIES = 1 << INDEX_W;

    logic [ENTRIES-1:0] valid;
    logic [TAG_W-1:0]   tags [ENTRIES];

    logic               sel_valid;
    logic [TAG_W-1:0]   sel_tag;

    // valid bits, flush beats a fill on the same edge.
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (fill) begin
            valid[req_index] <= 1'b1;
        end
    end

    // tag payload.
    always_ff @(posedge clk) begin
        if (fill) begin
            tags[req_index] <= req_tag;
        end
    end

    assign sel_valid = valid[req_index];
    assign sel_tag   = tags[req_index];

    // invalid entry masks whatever the tag holds.
    assign hit = sel_valid && (sel_tag == req_tag);

    // a fill leaves a matching, valid entry behind unless flushed
    property p_fill_lands;
        @(posedge clk) disable iff (!nrst)
        fill && !flush |=> valid[$past(req_index)] &&
                           (tags[$past(req_index)] == $past(req_tag));
    endproperty

    a_fill_lands: assert property (p_fill_lands)
        else $error("tag store entry not written by fill");

endmodule

//--- hdl/icache_miss_ctrl.sv
`timescale 1ns/1ps

module icache_miss_ctrl #(
    parameter int TAG_W   = icache_cfg_pkg::DEF_TAG_W,
    parameter int INDEX_W = icache_cfg_pkg::DEF_INDEX_W
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               read_req,
    input  logic [TAG_W-1:0]   tag,
    input  logic [INDEX_W-1:0] index,
    input  logic               l2_ready,
    input  logic               hit,
    output logic [TAG_W-1:0]   req_tag,
    output logic [INDEX_W-1:0] req_index,
    output logic               fill,
    output logic               stall,
    output logic               l2_read,
    output logic               refill
);

    import icache_state_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    logic accept;

    // only idle takes a new request.
    assign accept = (state == ST_IDLE) && read_req;

    // request latch, held through the whole miss.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag   <= tag;
            req_index <= index;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                // hit costs just this cycle.
                state_nxt = hit ? ST_IDLE : ST_MISS_WAIT;
            end
            ST_MISS_WAIT: begin
                if (l2_ready) begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_REFILL: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // write strobe on the ready edge.
    assign fill = (state == ST_MISS_WAIT) && l2_ready;

    // outputs straight from the state register.
    assign stall   = (state != ST_IDLE);
    assign l2_read = (state == ST_MISS_WAIT);
    assign refill  = (state == ST_REFILL);

    // refill is a single pulse and the core is released with it
    property p_refill_pulse;
        @(posedge clk) disable iff (!nrst)
        refill |=> !refill && !stall;
    endproperty

    // L2 is only asked after a lookup cycle that already stalled.
    property p_l2_read_stalled;
        @(posedge clk) disable iff (!nrst)
        l2_read |-> stall && $past(stall);
    endproperty

    // fill only on the L2 reply, and refill follows it.
    property p_fill_in_wait;
        @(posedge clk) disable iff (!nrst)
        fill |-> l2_read ##1 refill;
    endproperty

    a_refill_pulse: assert property (p_refill_pulse)
        else $error("refill longer than one cycle or stall held after it");

    a_l2_read_stalled: assert property (p_l2_read_stalled)
        else $error("l2_read without a preceding stall");

    a_fill_in_wait: assert property (p_fill_in_wait)
        else $error("fill outside the L2 wait");

endmodule

//--- hdl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int TAG_W   = icache_cfg_pkg::DEF_TAG_W,
    parameter int INDEX_W = icache_cfg_pkg::DEF_INDEX_W
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               read_req,
    input  logic [TAG_W-1:0]   tag,
    input  logic [INDEX_W-1:0] index,
    input  logic               flush,
    input  logic               l2_ready,
    output logic               stall,
    output logic               l2_read,
    output logic               refill
);

    // latched request toward the store.
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;

    logic fill;
    logic hit;

    icache_miss_ctrl #(
        .TAG_W   (TAG_W),
        .INDEX_W (INDEX_W)
    ) u_miss_ctrl (
        .clk       (clk),
        .nrst      (nrst),
        .read_req  (read_req),
        .tag       (tag),
        .index     (index),
        .l2_ready  (l2_ready),
        .hit       (hit),
        .req_tag   (req_tag),
        .req_index (req_index),
        .fill      (fill),
        .stall     (stall),
        .l2_read   (l2_read),
        .refill    (refill)
    );

    // flush bypasses the controller.
    icache_tag_store #(
        .TAG_W   (TAG_W),
        .INDEX_W (INDEX_W)
    ) u_tag_store (
        .clk       (clk),
        .nrst      (nrst),
        .flush     (flush),
        .fill      (fill),
        .req_index (req_index),
        .req_tag   (req_tag),
        .hit       (hit)
    );

endmodule

//--- bench/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// shadow of the tag store, kept by the stimulus side.
logic             shadow_valid [ENTRIES];
logic [TAG_W-1:0] shadow_tag   [ENTRIES];

// hit rule, a valid entry holding an equal tag.
function automatic logic ref_hit(input logic [TAG_W-1:0] t, input logic [INDEX_W-1:0] i);
    return shadow_valid[i] && (shadow_tag[i] == t);
endfunction

// L2 answered, so the entry now holds this tag.
task automatic shadow_fill(input logic [TAG_W-1:0] t, input logic [INDEX_W-1:0] i);
    shadow_valid[i] = 1'b1;
    shadow_tag[i]   = t;
endtask

task automatic shadow_clear();
    shadow_valid = '{default: 1'b0};
endtask

// 16-bit Galois LFSR, taps 16 14 13 11.
function automatic logic [15:0] galois_step(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 16'hB400;
    end
    return n;
endfunction

// small tag set, two differ only in the top bit.
function automatic logic [TAG_W-1:0] tag_from_set(input logic [1:0] k);
    case (k)
        2'd0:    return TAG_W'(52'h0_0000_0000_1A2B);
        2'd1:    return TAG_W'(52'hF_FFFF_0000_0042);
        2'd2:    return TAG_W'(52'h8_0000_0000_1A2B);
        default: return TAG_W'(52'h1_2345_6789_ABCD);
    endcase
endfunction

// small index set, ends of the array included.
function automatic logic [INDEX_W-1:0] index_from_set(input logic [1:0] k);
    case (k)
        2'd0:    return INDEX_W'(0);
        2'd1:    return INDEX_W'(5);
        2'd2:    return INDEX_W'(37);
        default: return INDEX_W'(63);
    endcase
endfunction

`endif

//--- bench/tb_icache_ctrl.sv
`timescale 1ns/1ps

module tb_icache_ctrl;

    import icache_cfg_pkg::*;

    localparam int TAG_W       = DEF_TAG_W;
    localparam int INDEX_W     = DEF_INDEX_W;
    localparam int ENTRIES     = 1 << INDEX_W;
    localparam int CLK_PERIOD  = 100;
    localparam int MAX_DELAY   = 7;
    localparam int N_RANDOM    = 200;
    localparam int N_REQ_BOUND = N_RANDOM + 40;

    // each request needs at most delay plus 4 cycles.
    localparam int WATCHDOG_CYCLES = N_REQ_BOUND * (MAX_DELAY + 4) + 200;

    logic               clk;
    logic               nrst;
    logic               read_req;
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic               flush;
    logic               l2_ready;
    logic               stall;
    logic               l2_read;
    logic               refill;

    logic [15:0] lfsr_state;

    // expected outcome per issued request in issue order.
    bit exp_hit_q [$];
    int exp_delay_q [$];

    int mismatch_count = 0;
    int fault_count    = 0;
    int checked_count  = 0;
    int issued_count   = 0;

    logic prev_stall    = 1'b0;
    logic reset_checked = 1'b0;
    logic last_refill   = 1'b0;
    int   stall_cycles  = 0;
    int   read_cycles   = 0;
    int   refill_cycles = 0;

    `include "tb_ref_model.svh"

    icache_ctrl #(
        .TAG_W   (TAG_W),
        .INDEX_W (INDEX_W)
    ) UUT (
        .clk      (clk),
        .nrst     (nrst),
        .read_req (read_req),
        .tag      (tag),
        .index    (index),
        .flush    (flush),
        .l2_ready (l2_ready),
        .stall    (stall),
        .l2_read  (l2_read),
        .refill   (refill)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
            mismatch_count++;
        end
    endtask

    task automatic draw_bits(input int n, output logic [7:0] value);
        int k;
        value = 8'd0;
        for (k = 0; k < n; k++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    // one core request where L2 answers after delay cycles of l2_read.
    task automatic run_request(input logic [TAG_W-1:0] t, input logic [INDEX_W-1:0] i,
                               input int delay, input bit hold);
        int waited;
        waited = 0;
        exp_hit_q.push_back(ref_hit(t, i));
        exp_delay_q.push_back(delay);
        issued_count++;
        read_req = 1'b1;
        tag      = t;
        index    = i;
        @(negedge clk);
        if (!hold) begin
            read_req = 1'b0;
        end
        while (stall === 1'b1) begin
            l2_ready = 1'b0;
            if (l2_read === 1'b1) begin
                if (waited == delay) begin
                    l2_ready = 1'b1;
                    shadow_fill(t, i);
                end
                waited++;
            end
            @(negedge clk);
        end
        l2_ready = 1'b0;
        read_req = 1'b0;
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        shadow_clear();
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // judge the finished request once stall falls.
    task automatic close_request();
        bit   exp_hit;
        int   delay;
        logic seen_hit;
        if (exp_hit_q.size() == 0) begin
            $display("stall was released with no request outstanding at %0t", $time);
            fault_count++;
        end else begin
            exp_hit  = exp_hit_q.pop_front();
            delay    = exp_delay_q.pop_front();
            seen_hit = (read_cycles == 0) && (refill_cycles == 0);
            checked_count++;
            check_value("hit", 32'(seen_hit), 32'(exp_hit));
            if (exp_hit) begin
                check_value("stall_cycles", stall_cycles, 1);
                check_value("l2_read_cycles", read_cycles, 0);
                check_value("refill_cycles", refill_cycles, 0);
            end else begin
                check_value("stall_cycles", stall_cycles, delay + 3);
                check_value("l2_read_cycles", read_cycles, delay + 1);
                check_value("refill_cycles", refill_cycles, 1);
                check_value("refill_at_release", 32'(last_refill), 32'd1);
            end
        end
    endtask

    // compare process samples outputs mid-cycle.
    always @(negedge clk) begin
        if (nrst === 1'b1) begin
            if (!reset_checked) begin
                check_value("stall", 32'(stall), 32'd0);
                check_value("l2_read", 32'(l2_read), 32'd0);
                check_value("refill", 32'(refill), 32'd0);
                reset_checked = 1'b1;
            end
            if (l2_read === 1'b1 || refill === 1'b1) begin
                check_value("stall", 32'(stall), 32'd1);
            end
            check_value("l2_read_and_refill", 32'(l2_read & refill), 32'd0);
            if (stall === 1'b1) begin
                if (prev_stall !== 1'b1) begin
                    stall_cycles  = 0;
                    read_cycles   = 0;
                    refill_cycles = 0;
                end
                stall_cycles++;
                if (l2_read === 1'b1) begin
                    read_cycles++;
                end
                if (refill === 1'b1) begin
                    refill_cycles++;
                end
                last_refill = refill;
            end else if (prev_stall === 1'b1) begin
                close_request();
            end
            prev_stall = stall;
        end
    end

    initial begin
        logic [7:0] r_tag;
        logic [7:0] r_index;
        logic [7:0] r_flush;
        logic [7:0] d;
        int         n;
        int         pending;
        nrst       = 1'b0;
        read_req   = 1'b0;
        tag        = '0;
        index      = '0;
        flush      = 1'b0;
        l2_ready   = 1'b0;
        lfsr_state = 16'd83;
        shadow_clear();
        repeat (8) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);

        // cold cache misses and then hits on the same lines.
        run_request(tag_from_set(2'd0), index_from_set(2'd0), 2, 1'b0);
        run_request(tag_from_set(2'd1), index_from_set(2'd1), 0, 1'b0);
        run_request(tag_from_set(2'd0), index_from_set(2'd0), 0, 1'b0);
        run_request(tag_from_set(2'd1), index_from_set(2'd1), 0, 1'b0);

        // read_req held through a miss.
        draw_bits(3, d);
        run_request(tag_from_set(2'd2), index_from_set(2'd2), int'(d), 1'b1);
        idle_cycles(3);
        run_request(tag_from_set(2'd2), index_from_set(2'd2), 0, 1'b0);

        // other tag on a resident index evicts it.
        run_request(tag_from_set(2'd3), index_from_set(2'd0), 3, 1'b0);
        run_request(tag_from_set(2'd0), index_from_set(2'd0), 1, 1'b0);
        run_request(tag_from_set(2'd0), index_from_set(2'd0), 0, 1'b0);
        run_request(tag_from_set(2'd3), index_from_set(2'd0), 4, 1'b0);

        flush_cache();
        run_request(tag_from_set(2'd1), index_from_set(2'd1), 1, 1'b0);
        run_request(tag_from_set(2'd2), index_from_set(2'd2), 0, 1'b0);
        run_request(tag_from_set(2'd3), index_from_set(2'd0), 5, 1'b0);
        run_request(tag_from_set(2'd1), index_from_set(2'd1), 0, 1'b0);

        for (n = 0; n < N_RANDOM; n++) begin
            draw_bits(4, r_flush);
            if (r_flush == 8'd0) begin
                flush_cache(); // about one in sixteen.
            end
            draw_bits(2, r_tag);
            draw_bits(2, r_index);
            draw_bits(3, d);
            run_request(tag_from_set(r_tag[1:0]), index_from_set(r_index[1:0]),
                        int'(d), 1'b0);
        end

        idle_cycles(4);
        pending = exp_hit_q.size();
        if (pending != 0) begin
            $display("%0d requests never released the stall", pending);
        end
        if (checked_count != issued_count) begin
            $display("only %0d of %0d requests were seen by the checker",
                     checked_count, issued_count);
        end
        $display("errors: %0d mismatches, %0d faults, %0d of %0d requests checked",
                 mismatch_count, fault_count, checked_count, issued_count);
        if (mismatch_count == 0 && fault_count == 0 && pending == 0 &&
            checked_count == issued_count) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog.
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+bench
hdl/icache_cfg_pkg.sv
hdl/icache_state_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_miss_ctrl.sv
hdl/icache_ctrl.sv
bench/tb_icache_ctrl.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_icache_ctrl
RTL_TOP    ?= icache_ctrl
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= STATUS: PASS
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint build sim clean

all: sim

# lint the RTL top level only
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides, a crashed run has no pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
